//--- include/pctrl_consts.svh
`ifndef PCTRL_CONSTS_SVH
`define PCTRL_CONSTS_SVH

// ------------------------------------------------
// Sizes
// ------------------------------------------------
// Controlled peripherals with one mask bit each
`define PCTRL_NUM_PERIPH   4
// Divide ratio is 2 to the power of the select
`define PCTRL_DIV_W        3
`define PCTRL_CNT_W        7
// Peripheral reset low time in master_clk cycles
`define PCTRL_RST_HOLD     8

// AHB-Lite data and decoded address width
`define PCTRL_DATA_W       32
`define PCTRL_ADDR_W       8

// ------------------------------------------------
// Register offsets
// ------------------------------------------------
`define PCTRL_ADDR_GATE    8'h00
`define PCTRL_ADDR_DIV     8'h04
`define PCTRL_ADDR_SRST_EN 8'h08
`define PCTRL_ADDR_RST_REQ 8'h0C
`define PCTRL_ADDR_RST_ACK 8'h10

`endif

//--- hdl/pctrl_pkg.sv
`include "pctrl_consts.svh"

package pctrl_pkg;

  // Bit position of each peripheral in every mask
  typedef enum logic [1:0] {
    TIMER0 = 2'd0,
    TIMER1 = 2'd1,
    UART0  = 2'd2,
    UART1  = 2'd3
  } periph_e;

  // AHB HTRANS encodings
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Address phase of one AHB-Lite transfer
  typedef struct packed {
    logic                     sel;
    htrans_e                  trans;
    logic                     write;
    logic [`PCTRL_ADDR_W-1:0] addr;
    logic                     ready;
  } ahb_req_t;

  // Register stage to clock enable stage
  typedef struct packed {
    logic [`PCTRL_NUM_PERIPH-1:0]                   gate;
    logic [`PCTRL_NUM_PERIPH-1:0][`PCTRL_DIV_W-1:0] div;
  } clk_ctrl_t;

  // Register stage to reset sequencer
  typedef struct packed {
    logic [`PCTRL_NUM_PERIPH-1:0] srst_en;
    logic [`PCTRL_NUM_PERIPH-1:0] req;
  } rst_ctrl_t;

  typedef enum logic {
    RST_HOLD = 1'b0,
    RST_RUN  = 1'b1
  } rst_state_e;

endpackage

//--- hdl/pctrl_regs.sv
`timescale 1ns/100ps
`include "pctrl_consts.svh"

module pctrl_regs (
  input  logic                         master_clk,
  input  logic                         rst_n,
  input  pctrl_pkg::ahb_req_t          ahb_req,
  input  logic [`PCTRL_DATA_W-1:0]     hwdata,
  input  logic [`PCTRL_NUM_PERIPH-1:0] rst_ack,
  output logic [`PCTRL_DATA_W-1:0]     hrdata,
  output logic                         hreadyout,
  output pctrl_pkg::clk_ctrl_t         clk_ctrl,
  output pctrl_pkg::rst_ctrl_t         rst_ctrl
);

  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_GATE,
    SEL_DIV,
    SEL_SRST_EN,
    SEL_RST_REQ,
    SEL_RST_ACK
  } reg_sel_e;

  logic                                           accept;
  reg_sel_e                                       addr_sel;
  logic                                           dp_valid;
  logic                                           dp_write;
  reg_sel_e                                       dp_sel;
  logic                                           wr_en;
  logic [`PCTRL_NUM_PERIPH-1:0]                   wr_bits;
  logic [`PCTRL_NUM_PERIPH-1:0]                   ack_clr;
  logic [`PCTRL_NUM_PERIPH-1:0]                   gate_q;
  logic [`PCTRL_NUM_PERIPH-1:0][`PCTRL_DIV_W-1:0] div_q;
  logic [`PCTRL_NUM_PERIPH-1:0]                   srst_en_q;
  logic [`PCTRL_NUM_PERIPH-1:0]                   req_q;
  logic [`PCTRL_NUM_PERIPH-1:0]                   ack_q;

  // ------------------------------------------------
  // Address phase
  // ------------------------------------------------
  assign accept = ahb_req.sel && ahb_req.ready &&
                  (ahb_req.trans == pctrl_pkg::NONSEQ || ahb_req.trans == pctrl_pkg::SEQ);

  always_comb begin
    case (ahb_req.addr)
      `PCTRL_ADDR_GATE:    addr_sel = SEL_GATE;
      `PCTRL_ADDR_DIV:     addr_sel = SEL_DIV;
      `PCTRL_ADDR_SRST_EN: addr_sel = SEL_SRST_EN;
      `PCTRL_ADDR_RST_REQ: addr_sel = SEL_RST_REQ;
      `PCTRL_ADDR_RST_ACK: addr_sel = SEL_RST_ACK;
      default:             addr_sel = SEL_NONE;
    endcase
  end

  always_ff @(posedge master_clk or negedge rst_n) begin
    if (!rst_n) begin
      dp_valid <= 1'b0;
      dp_write <= 1'b0;
      dp_sel   <= SEL_NONE;
    end else begin
      dp_valid <= accept;
      dp_write <= ahb_req.write;
      dp_sel   <= addr_sel;
    end
  end

  // ------------------------------------------------
  // Data phase
  // ------------------------------------------------
  assign wr_en   = dp_valid && dp_write;
  assign wr_bits = hwdata[`PCTRL_NUM_PERIPH-1:0];
  // Write-one-to-clear on the status register
  assign ack_clr = (wr_en && dp_sel == SEL_RST_ACK) ? wr_bits : '0;

  always_ff @(posedge master_clk or negedge rst_n) begin
    if (!rst_n) begin
      gate_q    <= '0;
      div_q     <= '0;
      srst_en_q <= '0;
      req_q     <= '0;
      ack_q     <= '0;
    end else begin
      // Request bits live for a single cycle
      req_q <= '0;
      // A new acknowledge wins over a clear in the same cycle
      ack_q <= (ack_q & ~ack_clr) | rst_ack;
      if (wr_en) begin
        case (dp_sel)
          SEL_GATE:    gate_q    <= wr_bits;
          SEL_DIV:     div_q     <= hwdata[`PCTRL_NUM_PERIPH*`PCTRL_DIV_W-1:0];
          SEL_SRST_EN: srst_en_q <= wr_bits;
          SEL_RST_REQ: req_q     <= wr_bits;
          default:     ;
        endcase
      end
    end
  end

  // Read data during the data phase
  // RST_REQ and holes read zero
  always_comb begin
    hrdata = '0;
    if (dp_valid && !dp_write) begin
      case (dp_sel)
        SEL_GATE:    hrdata[`PCTRL_NUM_PERIPH-1:0] = gate_q;
        SEL_DIV:     hrdata[`PCTRL_NUM_PERIPH*`PCTRL_DIV_W-1:0] = div_q;
        SEL_SRST_EN: hrdata[`PCTRL_NUM_PERIPH-1:0] = srst_en_q;
        SEL_RST_ACK: hrdata[`PCTRL_NUM_PERIPH-1:0] = ack_q;
        default:     hrdata = '0;
      endcase
    end
  end

  // No wait states
  assign hreadyout = 1'b1;

  assign clk_ctrl.gate    = gate_q;
  assign clk_ctrl.div     = div_q;
  assign rst_ctrl.srst_en = srst_en_q;
  assign rst_ctrl.req     = req_q;

endmodule

//--- hdl/pctrl_clk_en_gen.sv
`timescale 1ns/100ps
`include "pctrl_consts.svh"

module pctrl_clk_en_gen (
  input  logic                         master_clk,
  input  logic                         rst_n,
  input  pctrl_pkg::clk_ctrl_t         clk_ctrl,
  output logic [`PCTRL_NUM_PERIPH-1:0] clken
);

  logic [`PCTRL_CNT_W-1:0] cnt_q;

  // ------------------------------------------------
  // Shared divider counter
  // ------------------------------------------------
  // One 128-cycle wrap holds a whole period of every select
  always_ff @(posedge master_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // ------------------------------------------------
  // Per-peripheral qualifiers
  // ------------------------------------------------
  for (genvar i = 0; i < `PCTRL_NUM_PERIPH; i++) begin : g_qual
    logic [`PCTRL_CNT_W-1:0] low_mask;

    // Select n keeps the low n counter bits
    assign low_mask = ~({`PCTRL_CNT_W{1'b1}} << clk_ctrl.div[i]);

    // One cycle in every 2**select while the gate is on
    assign clken[i] = clk_ctrl.gate[i] && ((cnt_q & low_mask) == '0);
  end

endmodule

//--- hdl/pctrl_rst_seq.sv
`timescale 1ns/100ps
`include "pctrl_consts.svh"

module pctrl_rst_seq (
  input  logic                         master_clk,
  input  logic                         rst_n,
  input  pctrl_pkg::rst_ctrl_t         rst_ctrl,
  input  logic                         sys_reset_req,
  output logic [`PCTRL_NUM_PERIPH-1:0] periph_rst_n,
  output logic [`PCTRL_NUM_PERIPH-1:0] rst_ack
);

  localparam int HOLD_W = $clog2(`PCTRL_RST_HOLD);
  localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`PCTRL_RST_HOLD - 1);

  logic [`PCTRL_NUM_PERIPH-1:0] trigger;

  // Software pulse or system request where enabled
  assign trigger = rst_ctrl.req | ({`PCTRL_NUM_PERIPH{sys_reset_req}} & rst_ctrl.srst_en);

  // ------------------------------------------------
  // One sequencer per peripheral
  // ------------------------------------------------
  for (genvar i = 0; i < `PCTRL_NUM_PERIPH; i++) begin : g_seq
    pctrl_pkg::rst_state_e state_q;
    logic [HOLD_W-1:0]     cnt_q;
    logic                  ack_q;

    // Starts in HOLD so every peripheral sees a full reset after rst_n
    always_ff @(posedge master_clk or negedge rst_n) begin
      if (!rst_n) begin
        state_q <= pctrl_pkg::RST_HOLD;
        cnt_q   <= '0;
        ack_q   <= 1'b0;
      end else begin
        ack_q <= 1'b0;
        case (state_q)
          pctrl_pkg::RST_RUN: begin
            // Requests during HOLD are dropped
            if (trigger[i]) begin
              state_q <= pctrl_pkg::RST_HOLD;
              cnt_q   <= '0;
            end
          end
          default: begin
            if (cnt_q == HOLD_LAST) begin
              state_q <= pctrl_pkg::RST_RUN;
              ack_q   <= 1'b1;
            end else begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
        endcase
      end
    end

    // ack_q lines up with the first cycle out of reset
    assign periph_rst_n[i] = (state_q == pctrl_pkg::RST_RUN);
    assign rst_ack[i]      = ack_q;
  end

endmodule

//--- hdl/platform_ctrl.sv
`timescale 1ns/100ps
`include "pctrl_consts.svh"

module platform_ctrl (
  input  logic                         master_clk,
  input  logic                         rst_n,
  input  pctrl_pkg::ahb_req_t          ahb_req,
  input  logic [`PCTRL_DATA_W-1:0]     hwdata,
  input  logic                         sys_reset_req,
  output logic [`PCTRL_DATA_W-1:0]     hrdata,
  output logic                         hreadyout,
  output logic [`PCTRL_NUM_PERIPH-1:0] clken,
  output logic [`PCTRL_NUM_PERIPH-1:0] periph_rst_n
);

  pctrl_pkg::clk_ctrl_t         clk_ctrl;
  pctrl_pkg::rst_ctrl_t         rst_ctrl;
  logic [`PCTRL_NUM_PERIPH-1:0] rst_ack;

  // ------------------------------------------------
  // Register space
  // ------------------------------------------------
  pctrl_regs u_regs (
    .master_clk (master_clk),
    .rst_n      (rst_n),
    .ahb_req    (ahb_req),
    .hwdata     (hwdata),
    .rst_ack    (rst_ack),
    .hrdata     (hrdata),
    .hreadyout  (hreadyout),
    .clk_ctrl   (clk_ctrl),
    .rst_ctrl   (rst_ctrl)
  );

  // ------------------------------------------------
  // Clock qualifiers
  // ------------------------------------------------
  pctrl_clk_en_gen u_clk_en_gen (
    .master_clk (master_clk),
    .rst_n      (rst_n),
    .clk_ctrl   (clk_ctrl),
    .clken      (clken)
  );

  // ------------------------------------------------
  // Peripheral resets
  // ------------------------------------------------
  // Acknowledges loop back into the sticky status register
  pctrl_rst_seq u_rst_seq (
    .master_clk    (master_clk),
    .rst_n         (rst_n),
    .rst_ctrl      (rst_ctrl),
    .sys_reset_req (sys_reset_req),
    .periph_rst_n  (periph_rst_n),
    .rst_ack       (rst_ack)
  );

endmodule

//--- verification/platform_ctrl_assertions.sv
`timescale 1ns/100ps
`include "pctrl_consts.svh"

module platform_ctrl_assertions (
  input logic                         master_clk,
  input logic                         rst_n,
  input logic                         hreadyout,
  input logic [`PCTRL_NUM_PERIPH-1:0] clken,
  input logic [`PCTRL_NUM_PERIPH-1:0] periph_rst_n,
  input logic [`PCTRL_NUM_PERIPH-1:0] rst_ack,
  input pctrl_pkg::clk_ctrl_t         clk_ctrl
);

  int fail_cnt = 0;

  a_hready: assert property (@(posedge master_clk) disable iff (!rst_n) hreadyout)
    else begin
      fail_cnt++;
      $error("hreadyout went low");
    end

  for (genvar i = 0; i < `PCTRL_NUM_PERIPH; i++) begin : g_periph
    logic [7:0] low_len;

    // Cycles spent in the current low period
    always_ff @(posedge master_clk or negedge rst_n) begin
      if (!rst_n) begin
        low_len <= '0;
      end else if (!periph_rst_n[i]) begin
        low_len <= low_len + 8'd1;
      end else begin
        low_len <= '0;
      end
    end

    a_hold: assert property (@(posedge master_clk) disable iff (!rst_n)
      $rose(periph_rst_n[i]) |-> low_len == 8'(`PCTRL_RST_HOLD))
      else begin
        fail_cnt++;
        $error("periph %0d reset low for %0d cycles", i, low_len);
      end

    a_ack: assert property (@(posedge master_clk) disable iff (!rst_n)
      rst_ack[i] |-> $rose(periph_rst_n[i]))
      else begin
        fail_cnt++;
        $error("periph %0d acknowledge without reset release", i);
      end

    a_gate: assert property (@(posedge master_clk) disable iff (!rst_n)
      !clk_ctrl.gate[i] |-> !clken[i])
      else begin
        fail_cnt++;
        $error("periph %0d clken high with gate clear", i);
      end
  end

endmodule

bind platform_ctrl platform_ctrl_assertions u_assertions (
  .master_clk   (master_clk),
  .rst_n        (rst_n),
  .hreadyout    (hreadyout),
  .clken        (clken),
  .periph_rst_n (periph_rst_n),
  .rst_ack      (rst_ack),
  .clk_ctrl     (clk_ctrl)
);

//--- verification/platform_ctrl_checker.sv
`timescale 1ns/100ps
`include "pctrl_consts.svh"

module platform_ctrl_checker (
  input logic                         master_clk,
  input logic                         rst_n,
  input logic [`PCTRL_NUM_PERIPH-1:0] clken,
  input logic [`PCTRL_NUM_PERIPH-1:0] periph_rst_n
);

  localparam int NP     = `PCTRL_NUM_PERIPH;
  localparam int WINDOW = 256;

  // Running totals kept by the watcher
  int unsigned pulse_tot [NP] = '{default: 0};
  int unsigned fall_tot  [NP] = '{default: 0};
  int unsigned rise_tot  [NP] = '{default: 0};
  int unsigned bad_tot   [NP] = '{default: 0};
  int unsigned low_cnt   [NP] = '{default: 0};
  // Snapshot taken at the start of a window
  int unsigned pulse_mark [NP] = '{default: 0};
  int unsigned fall_mark  [NP] = '{default: 0};
  int unsigned rise_mark  [NP] = '{default: 0};
  int unsigned bad_mark   [NP] = '{default: 0};

  string cur_test     = "";
  int    test_errs    = 0;
  int    tests_run    = 0;
  int    tests_failed = 0;
  int    checks       = 0;
  int    err_cnt      = 0;

  // --------------------------------------------------
  // Watcher sampling mid-cycle
  // --------------------------------------------------
  always @(negedge master_clk) begin
    for (int i = 0; i < NP; i++) begin
      if (clken[i]) pulse_tot[i]++;
      if (!rst_n) begin
        low_cnt[i] = 0;
      end else if (!periph_rst_n[i]) begin
        if (low_cnt[i] == 0) fall_tot[i]++;
        low_cnt[i]++;
      end else if (low_cnt[i] != 0) begin
        rise_tot[i]++;
        if (low_cnt[i] != `PCTRL_RST_HOLD) bad_tot[i]++;
        low_cnt[i] = 0;
      end
    end
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [31:0] ref_readback(input logic [7:0] addr, input logic [31:0] wdata);
    case (addr)
      `PCTRL_ADDR_GATE, `PCTRL_ADDR_SRST_EN: return wdata & ((32'h1 << NP) - 1);
      `PCTRL_ADDR_DIV: return wdata & ((32'h1 << (NP * `PCTRL_DIV_W)) - 1);
      default: return 32'h0;
    endcase
  endfunction

  // Pulses of one qualifier in a full window
  function automatic logic [31:0] ref_pulses(input logic gate_on, input logic [2:0] sel);
    return gate_on ? (32'(WINDOW) >> sel) : 32'h0;
  endfunction

  function automatic logic [NP-1:0] ref_reset_mask(input logic [NP-1:0] req, input logic sys,
                                                   input logic [NP-1:0] en);
    logic [NP-1:0] hit;
    hit = req;
    if (sys) begin
      hit = hit | en;
    end
    return hit;
  endfunction

  // --------------------------------------------------
  // Comparisons and bookkeeping
  // --------------------------------------------------
  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", cur_test, test_errs);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      test_errs++;
      err_cnt++;
      $display("ERR %s (%s) expected 0x%h actual 0x%h", cur_test, what, exp, act);
    end
  endtask

  task automatic mark();
    pulse_mark = pulse_tot;
    fall_mark  = fall_tot;
    rise_mark  = rise_tot;
    bad_mark   = bad_tot;
  endtask

  task automatic check_read(input string what, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic [31:0] rdata);
    check_value(what, ref_readback(addr, wdata), rdata);
  endtask

  task automatic check_pulses(input string what, input logic [NP-1:0] gate,
                              input logic [NP*`PCTRL_DIV_W-1:0] div);
    for (int i = 0; i < NP; i++) begin
      check_value($sformatf("%s clken%0d", what, i),
                  ref_pulses(gate[i], div[i*`PCTRL_DIV_W +: `PCTRL_DIV_W]),
                  pulse_tot[i] - pulse_mark[i]);
    end
  endtask

  task automatic check_resets(input string what, input logic [NP-1:0] req, input logic sys,
                              input logic [NP-1:0] en);
    logic [NP-1:0] fell;
    logic [NP-1:0] rose;
    logic [NP-1:0] bad;
    for (int i = 0; i < NP; i++) begin
      fell[i] = (fall_tot[i] != fall_mark[i]);
      rose[i] = (rise_tot[i] != rise_mark[i]);
      bad[i]  = (bad_tot[i] != bad_mark[i]);
    end
    check_value({what, " low"}, 32'(ref_reset_mask(req, sys, en)), 32'(fell));
    check_value({what, " released"}, 32'(ref_reset_mask(req, sys, en)), 32'(rose));
    check_value({what, " hold length"}, 32'h0, 32'(bad));
  endtask

endmodule

//--- verification/platform_ctrl_tb.sv
`timescale 1ns/100ps
`include "pctrl_consts.svh"

module platform_ctrl_tb;

  localparam int NP         = `PCTRL_NUM_PERIPH;
  localparam int WINDOW     = 256;
  localparam int WAIT_LIMIT = 100;
  localparam pctrl_pkg::ahb_req_t IDLE_REQ =
    '{sel: 1'b0, trans: pctrl_pkg::IDLE, write: 1'b0, addr: 8'h00, ready: 1'b1};

  logic                     master_clk = 1'b0;
  logic                     rst_n;
  pctrl_pkg::ahb_req_t      ahb_req;
  logic [`PCTRL_DATA_W-1:0] hwdata;
  logic                     sys_reset_req;
  logic [`PCTRL_DATA_W-1:0] hrdata;
  logic                     hreadyout;
  logic [NP-1:0]            clken;
  logic [NP-1:0]            periph_rst_n;
  logic [31:0]              lfsr_state;
  int                       timeouts;

  platform_ctrl UUT (
    .master_clk    (master_clk),
    .rst_n         (rst_n),
    .ahb_req       (ahb_req),
    .hwdata        (hwdata),
    .sys_reset_req (sys_reset_req),
    .hrdata        (hrdata),
    .hreadyout     (hreadyout),
    .clken         (clken),
    .periph_rst_n  (periph_rst_n)
  );

  platform_ctrl_checker u_chk (
    .master_clk   (master_clk),
    .rst_n        (rst_n),
    .clken        (clken),
    .periph_rst_n (periph_rst_n)
  );

  always #5 master_clk = ~master_clk;

  // --------------------------------------------------
  // Random source and bus helpers
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Returns on the first edge that sees hreadyout high
  task automatic wait_ready();
    int n;
    n = 0;
    do begin
      @(posedge master_clk);
      n++;
    end while (!hreadyout && n < WAIT_LIMIT);
    if (!hreadyout) begin
      timeouts++;
      $display("timeout: hreadyout stayed low for %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge master_clk);
    ahb_req <= '{sel: 1'b1, trans: pctrl_pkg::NONSEQ, write: 1'b1, addr: addr, ready: 1'b1};
    wait_ready();
    ahb_req <= IDLE_REQ;
    hwdata  <= data;
    wait_ready();
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge master_clk);
    ahb_req <= '{sel: 1'b1, trans: pctrl_pkg::NONSEQ, write: 1'b0, addr: addr, ready: 1'b1};
    wait_ready();
    ahb_req <= IDLE_REQ;
    @(negedge master_clk);
    data = hrdata;
    wait_ready();
  endtask

  // Waits until every peripheral is out of reset again
  task automatic wait_resets_done();
    int n;
    n = 0;
    do begin
      @(negedge master_clk);
      n++;
    end while ((n < 2 || periph_rst_n != '1) && n < WAIT_LIMIT);
    if (periph_rst_n != '1) begin
      timeouts++;
      $display("timeout: peripheral resets still held after %0d cycles", WAIT_LIMIT);
    end
    @(posedge master_clk);
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin : main
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [3:0]  mask;
    logic [3:0]  gate;
    logic [11:0] div;
    logic [7:0]  offs [4];

    offs = '{`PCTRL_ADDR_GATE, `PCTRL_ADDR_DIV, `PCTRL_ADDR_SRST_EN, 8'h14};
    lfsr_state = 32'd68043;
    timeouts = 0;
    rst_n         <= 1'b0;
    ahb_req       <= IDLE_REQ;
    hwdata        <= '0;
    sys_reset_req <= 1'b0;
    repeat (4) @(posedge master_clk);
    rst_n <= 1'b1;

    u_chk.begin_test("power_up");
    wait_resets_done();
    u_chk.check_resets("periph resets", 4'hF, 1'b0, 4'h0);
    u_chk.mark();
    repeat (WINDOW) @(posedge master_clk);
    u_chk.check_pulses("idle", 4'h0, 12'h0);
    u_chk.end_test();

    u_chk.begin_test("readback");
    for (int k = 0; k < 4; k++) begin
      wdata = rand_bits(32);
      bus_write(offs[k], wdata);
      bus_read(offs[k], rdata);
      u_chk.check_read($sformatf("offset 0x%h", offs[k]), offs[k], wdata, rdata);
    end
    // Written request bits must not show up on a read
    wdata = rand_bits(32) | 32'h0000_000F;
    bus_write(`PCTRL_ADDR_RST_REQ, wdata);
    bus_read(`PCTRL_ADDR_RST_REQ, rdata);
    u_chk.check_read("offset rst_req", `PCTRL_ADDR_RST_REQ, wdata, rdata);
    u_chk.end_test();

    // Full gate, random gate, then gate cleared
    u_chk.begin_test("clken_rate");
    for (int k = 0; k < 3; k++) begin
      div  = 12'(rand_bits(12));
      gate = (k == 0) ? 4'hF : (k == 1) ? 4'(rand_bits(4)) : 4'h0;
      bus_write(`PCTRL_ADDR_DIV, {20'h0, div});
      bus_write(`PCTRL_ADDR_GATE, {28'h0, gate});
      u_chk.mark();
      repeat (WINDOW) @(posedge master_clk);
      u_chk.check_pulses($sformatf("round %0d", k), gate, div);
    end
    u_chk.end_test();

    u_chk.begin_test("sw_reset");
    for (int k = 0; k < 2; k++) begin
      mask = 4'(rand_bits(4));
      u_chk.mark();
      bus_write(`PCTRL_ADDR_RST_REQ, {28'h0, mask});
      wait_resets_done();
      u_chk.check_resets($sformatf("mask 0x%h", mask), mask, 1'b0, 4'h0);
    end
    u_chk.end_test();

    u_chk.begin_test("sys_reset");
    mask = 4'(rand_bits(4));
    bus_write(`PCTRL_ADDR_SRST_EN, {28'h0, mask});
    u_chk.mark();
    @(posedge master_clk);
    sys_reset_req <= 1'b1;
    @(posedge master_clk);
    sys_reset_req <= 1'b0;
    wait_resets_done();
    u_chk.check_resets($sformatf("enable 0x%h", mask), 4'h0, 1'b1, mask);
    u_chk.end_test();

    // Sticky status cleared by writing ones
    u_chk.begin_test("rst_ack");
    bus_write(`PCTRL_ADDR_RST_ACK, 32'hF);
    bus_read(`PCTRL_ADDR_RST_ACK, rdata);
    u_chk.check_value("initial clear", 32'h0, rdata);
    mask = 4'(rand_bits(4)) | 4'h1;
    bus_write(`PCTRL_ADDR_RST_REQ, {28'h0, mask});
    wait_resets_done();
    bus_read(`PCTRL_ADDR_RST_ACK, rdata);
    u_chk.check_value("after reset", 32'(u_chk.ref_reset_mask(mask, 1'b0, 4'h0)), rdata);
    bus_write(`PCTRL_ADDR_RST_ACK, {28'h0, mask});
    bus_read(`PCTRL_ADDR_RST_ACK, rdata);
    u_chk.check_value("after clear", 32'h0, rdata);
    u_chk.end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d, timeouts %0d, assertion fails %0d",
             u_chk.tests_run, u_chk.tests_failed, u_chk.checks, u_chk.err_cnt, timeouts,
             UUT.u_assertions.fail_cnt);
    if (u_chk.err_cnt == 0 && timeouts == 0 && UUT.u_assertions.fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
hdl/pctrl_pkg.sv
hdl/pctrl_regs.sv
hdl/pctrl_clk_en_gen.sv
hdl/pctrl_rst_seq.sv
hdl/platform_ctrl.sv
verification/platform_ctrl_assertions.sv
verification/platform_ctrl_checker.sv
verification/platform_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the output
verilator --binary --timing --assert --top-module platform_ctrl_tb -f vlog.f \
  -o platform_ctrl_sim || { echo "verilator build failed"; exit 1; }
result=$(./obj_dir/platform_ctrl_sim +verilator+error+limit+100)
echo "$result"
echo "$result" | grep -q "^TB PASSED$" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
